//--- list.f
rtl/procPkg.sv
rtl/pipeReg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/hazard.sv
rtl/memAccess.sv
rtl/proc.sv
tb/procTb.sv

//--- rtl/decode.sv
/*
   Instruction decode and the 8x16 register file.
   All registers read as zero after reset.
   A write from MEM/WB in the same cycle is bypassed to the read ports.
   Unknown opcodes decode as NOP with illegal set.
*/
module decode import procPkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  ifIdT  inst,
   input  memWbT wb,
   output idExT  decoded
);

   wordT regs [8];
   srcT  src;
   wordT imm6;
   wordT imm9;
   wordT rsData;
   wordT rtData;
   logic wbWrite;

   assign src     = srcRegs(inst.instr);
   assign imm6    = {{10{inst.instr[5]}}, inst.instr[5:0]};
   assign imm9    = {{7{inst.instr[8]}}, inst.instr[8:0]};
   assign wbWrite = wb.valid && wb.regWrite;

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (wbWrite) begin
         regs[wb.rd] <= wb.wbData;
      end
   end

   // Write-before-read
   assign rsData = (wbWrite && wb.rd == src.rs) ? wb.wbData : regs[src.rs];
   assign rtData = (wbWrite && wb.rd == src.rt) ? wb.wbData : regs[src.rt];

   always_comb begin
      decoded.valid    = inst.valid;
      decoded.op       = opT'(inst.instr[15:12]);
      decoded.rd       = inst.instr[11:9];
      decoded.rs       = src.rs;
      decoded.rt       = src.rt;
      decoded.rsData   = rsData;
      decoded.rtData   = rtData;
      decoded.imm      = imm6;
      decoded.pcInc    = inst.pcInc;
      decoded.regWrite = 1'b0;
      decoded.memRead  = 1'b0;
      decoded.memWrite = 1'b0;
      decoded.illegal  = 1'b0;
      decoded.halt     = 1'b0;
      case (inst.instr[15:12])
         OpNop: ;
         OpAdd, OpSub, OpAnd, OpXor, OpAddi: decoded.regWrite = 1'b1;
         OpLbi: begin
            decoded.regWrite = 1'b1;
            decoded.imm      = imm9;
         end
         OpLd: begin
            decoded.regWrite = 1'b1;
            decoded.memRead  = 1'b1;
         end
         OpSt:   decoded.memWrite = 1'b1;
         OpBeqz: decoded.imm = imm9;
         OpHalt: decoded.halt = 1'b1;
         default: begin
            decoded.op      = OpNop;
            decoded.illegal = 1'b1;
         end
      endcase
   end

endmodule

//--- rtl/execute.sv
/*
   Execute stage: operand forwarding, ALU and BEQZ resolution.
   LD/ST addresses are rs plus the 6-bit immediate.
   A taken BEQZ jumps to PC+1 plus the 9-bit immediate.
*/
module execute import procPkg::*; (
   input  idExT  inst,
   input  fwdT   fwdRs,
   input  fwdT   fwdRt,
   input  wordT  exMemData,
   input  wordT  memWbData,
   output exMemT result,
   output logic  redirect,
   output wordT  redirectPc
);

   wordT a;
   wordT b;
   wordT aluOut;

   function automatic wordT fwdMux(fwdT sel, wordT regVal, wordT exVal, wordT wbVal);
      case (sel)
         FwdExMem: return exVal;
         FwdMemWb: return wbVal;
         default:  return regVal;
      endcase
   endfunction

   assign a = fwdMux(fwdRs, inst.rsData, exMemData, memWbData);
   assign b = fwdMux(fwdRt, inst.rtData, exMemData, memWbData);

   always_comb begin
      case (inst.op)
         OpAdd:   aluOut = a + b;
         OpSub:   aluOut = a - b;
         OpAnd:   aluOut = a & b;
         OpXor:   aluOut = a ^ b;
         OpLbi:   aluOut = inst.imm;
         // ADDI and memory address
         default: aluOut = a + inst.imm;
      endcase
   end

   assign redirect   = inst.valid && (inst.op == OpBeqz) && (a == '0);
   assign redirectPc = inst.pcInc + inst.imm;

   assign result.valid     = inst.valid;
   assign result.rd        = inst.rd;
   assign result.aluOut    = aluOut;
   assign result.storeData = b;
   assign result.regWrite  = inst.regWrite;
   assign result.memRead   = inst.memRead;
   assign result.memWrite  = inst.memWrite;
   assign result.illegal   = inst.illegal;
   assign result.halt      = inst.halt;

endmodule

//--- rtl/fetch.sv
/*
   Instruction fetch over a four-phase req/ack port.
   imemAddr is held from request until ack falls; ack latency may vary.
   A word that arrives while the pipe is stalled waits in a one-entry buffer
   and no new request starts until it drains. A redirect mid-handshake lets
   the handshake finish and drops the returned word.
*/
module fetch import procPkg::*; #(
   parameter wordT ResetPc = '0
) (
   input  logic clk,
   input  logic rst,
   input  logic stall,
   input  logic redirect,
   input  wordT redirectPc,
   input  logic halted,
   output logic imemReq,
   output wordT imemAddr,
   input  logic imemAck,
   input  wordT imemData,
   output ifIdT fetched
);

   typedef enum logic [1:0] {Idle, WaitAck, WaitAckLow} stateT;

   stateT state;
   wordT  pc;
   logic  discard;
   logic  bufValid;
   ifIdT  bufWord;
   ifIdT  liveWord;
   logic  startReq;

   assign imemReq  = (state == WaitAck);
   assign startReq = (state == Idle) && !halted && !bufValid && !redirect;

   assign liveWord.valid = (state == WaitAck) && imemAck && !discard;
   assign liveWord.pc    = imemAddr;
   assign liveWord.pcInc = imemAddr + 16'd1;
   assign liveWord.instr = imemData;

   // Buffered word is older than anything still in flight
   assign fetched = bufValid ? bufWord : liveWord;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= Idle;
         pc       <= ResetPc;
         discard  <= 1'b0;
         bufValid <= 1'b0;
      end else begin
         case (state)
            Idle: begin
               if (startReq) begin
                  state   <= WaitAck;
                  discard <= 1'b0;
               end
            end
            WaitAck:    if (imemAck)  state <= WaitAckLow;
            WaitAckLow: if (!imemAck) state <= Idle;
            default:    state <= Idle;
         endcase

         if (redirect) begin
            pc <= redirectPc;
            if (state == WaitAck && !imemAck) begin
               discard <= 1'b1;
            end
         end else if (startReq) begin
            pc <= pc + 16'd1;
         end

         if (redirect) begin
            bufValid <= 1'b0;
         end else if (bufValid) begin
            bufValid <= stall;
         end else if (stall && liveWord.valid) begin
            bufValid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (startReq) begin
         imemAddr <= pc;
      end
      if (!bufValid && stall && liveWord.valid) begin
         bufWord <= liveWord;
      end
   end

endmodule

//--- rtl/hazard.sv
/*
   Forwarding selects for EX and the load-use stall.
   The nearest older writer wins; register 0 is an ordinary register.
   A load in EX/MEM is never a forwarding source since the stall separates it.
*/
module hazard import procPkg::*; (
   input  logic  clk,
   input  ifIdT  ifIdInst,
   input  idExT  idExInst,
   input  exMemT exMemInst,
   input  memWbT memWbInst,
   output logic  stall,
   output fwdT   fwdRs,
   output fwdT   fwdRt
);

   srcT ifIdSrc;

   function automatic fwdT fwdSel(regIdxT r, exMemT older, memWbT oldest);
      if (older.valid && older.regWrite && !older.memRead && older.rd == r) begin
         return FwdExMem;
      end else if (oldest.valid && oldest.regWrite && oldest.rd == r) begin
         return FwdMemWb;
      end
      return FwdNone;
   endfunction

   assign ifIdSrc = srcRegs(ifIdInst.instr);

   // Load in EX with its result needed by the instruction in ID
   assign stall = ifIdInst.valid && idExInst.valid && idExInst.memRead &&
                  ((ifIdSrc.useRs && ifIdSrc.rs == idExInst.rd) ||
                   (ifIdSrc.useRt && ifIdSrc.rt == idExInst.rd));

   assign fwdRs = fwdSel(idExInst.rs, exMemInst, memWbInst);
   assign fwdRt = fwdSel(idExInst.rt, exMemInst, memWbInst);

endmodule

//--- rtl/memAccess.sv
/*
   Data memory stage. Addresses wrap modulo DmemWords, which should be
   a power of two. Memory contents are undefined until stored.
   Reads are combinational and the write lands at the clock edge.
*/
module memAccess import procPkg::*; #(
   parameter int DmemWords = 256
) (
   input  logic  clk,
   input  exMemT inst,
   output wordT  loadData,
   output memWbT result
);

   localparam int AddrBits = $clog2(DmemWords);

   wordT                mem [DmemWords];
   logic [AddrBits-1:0] addr;

   assign addr = AddrBits'(inst.aluOut % DmemWords);

   always_ff @(posedge clk) begin
      if (inst.valid && inst.memWrite) begin
         mem[addr] <= inst.storeData;
      end
   end

   assign loadData = mem[addr];

   assign result.valid    = inst.valid;
   assign result.rd       = inst.rd;
   assign result.wbData   = inst.memRead ? loadData : inst.aluOut;
   assign result.regWrite = inst.regWrite;
   assign result.illegal  = inst.illegal;
   assign result.halt     = inst.halt;

endmodule

//--- rtl/pipeReg.sv
/*
   Stage register for any payload struct with a valid field.
   Reset and flush clear only valid; flush takes priority over hold.
*/
module pipeReg import procPkg::*; #(
   parameter type payloadT = ifIdT
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    hold,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         q.valid <= 1'b0;
      end else if (!hold) begin
         q <= d;
      end
   end

endmodule

//--- rtl/proc.sv
/*
   Five-stage 16-bit core: fetch, decode, execute, memory, writeback.
   HALT or an illegal opcode freezes MEM/WB, so halt (and err) stay high
   until reset. The younger instruction behind it is squashed before MEM.
   retireValid pulses once per register write, in program order.
*/
module proc import procPkg::*; #(
   parameter wordT ResetPc   = '0,
   parameter int   DmemWords = 256
) (
   input  logic   clk,
   input  logic   rst,
   output logic   imemReq,
   output wordT   imemAddr,
   input  logic   imemAck,
   input  wordT   imemData,
   output logic   retireValid,
   output regIdxT retireReg,
   output wordT   retireData,
   output logic   halt,
   output logic   err
);

   ifIdT  fetched, ifIdQ;
   idExT  decoded, idExQ;
   exMemT exResult, exMemQ;
   memWbT memResult, memWbQ;
   logic  stall, redirect, haltAhead;
   wordT  redirectPc;
   fwdT   fwdRs, fwdRt;

   // Halting instruction about to enter MEM/WB
   assign haltAhead = exMemQ.valid && (exMemQ.halt || exMemQ.illegal);

   assign halt        = memWbQ.valid && (memWbQ.halt || memWbQ.illegal);
   assign err         = memWbQ.valid && memWbQ.illegal;
   assign retireValid = memWbQ.valid && memWbQ.regWrite;
   assign retireReg   = memWbQ.rd;
   assign retireData  = memWbQ.wbData;

   fetch #(.ResetPc(ResetPc)) fetch0 (
      .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
      .redirectPc(redirectPc), .halted(halt), .imemReq(imemReq),
      .imemAddr(imemAddr), .imemAck(imemAck), .imemData(imemData),
      .fetched(fetched));

   pipeReg #(.payloadT(ifIdT)) ifId (
      .clk(clk), .rst(rst), .hold(stall), .flush(redirect), .d(fetched), .q(ifIdQ));

   decode decode0 (
      .clk(clk), .rst(rst), .inst(ifIdQ), .wb(memWbQ), .decoded(decoded));

   pipeReg #(.payloadT(idExT)) idEx (
      .clk(clk), .rst(rst), .hold(1'b0), .flush(stall || redirect),
      .d(decoded), .q(idExQ));

   hazard hazard0 (
      .clk(clk), .ifIdInst(ifIdQ), .idExInst(idExQ), .exMemInst(exMemQ),
      .memWbInst(memWbQ), .stall(stall), .fwdRs(fwdRs), .fwdRt(fwdRt));

   execute execute0 (
      .inst(idExQ), .fwdRs(fwdRs), .fwdRt(fwdRt), .exMemData(exMemQ.aluOut),
      .memWbData(memWbQ.wbData), .result(exResult), .redirect(redirect),
      .redirectPc(redirectPc));

   pipeReg #(.payloadT(exMemT)) exMem (
      .clk(clk), .rst(rst), .hold(1'b0), .flush(haltAhead || halt),
      .d(exResult), .q(exMemQ));

   memAccess #(.DmemWords(DmemWords)) memAccess0 (
      .clk(clk), .inst(exMemQ), .loadData(), .result(memResult));

   pipeReg #(.payloadT(memWbT)) memWb (
      .clk(clk), .rst(rst), .hold(halt), .flush(1'b0), .d(memResult), .q(memWbQ));

endmodule

//--- rtl/procPkg.sv
/*
   Shared types for the 16-bit five-stage core.
   Opcodes 4'hB to 4'hF are illegal and halt the core with err set.
   ST takes its store data from the rd field and BEQZ tests the rd field,
   so srcRegs maps both onto the rs/rt read ports.
*/
package procPkg;

   typedef logic [15:0] wordT;
   typedef logic [2:0]  regIdxT;

   typedef enum logic [3:0] {
      OpNop  = 4'h0,
      OpAdd  = 4'h1,
      OpSub  = 4'h2,
      OpAnd  = 4'h3,
      OpXor  = 4'h4,
      OpAddi = 4'h5,
      OpLbi  = 4'h6,
      OpLd   = 4'h7,
      OpSt   = 4'h8,
      OpBeqz = 4'h9,
      OpHalt = 4'hA
   } opT;

   // Operand source for the EX stage
   typedef enum logic [1:0] {FwdNone, FwdExMem, FwdMemWb} fwdT;

   typedef struct packed {
      logic   valid;
      wordT   pc;
      wordT   pcInc;
      wordT   instr;
   } ifIdT;

   typedef struct packed {
      logic   valid;
      opT     op;
      regIdxT rd;
      regIdxT rs;
      regIdxT rt;
      wordT   rsData;
      wordT   rtData;
      wordT   imm;
      wordT   pcInc;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      logic   illegal;
      logic   halt;
   } idExT;

   typedef struct packed {
      logic   valid;
      regIdxT rd;
      wordT   aluOut;
      wordT   storeData;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      logic   illegal;
      logic   halt;
   } exMemT;

   typedef struct packed {
      logic   valid;
      regIdxT rd;
      wordT   wbData;
      logic   regWrite;
      logic   illegal;
      logic   halt;
   } memWbT;

   typedef struct packed {
      logic   useRs;
      logic   useRt;
      regIdxT rs;
      regIdxT rt;
   } srcT;

   // Registers an instruction actually reads
   function automatic srcT srcRegs(wordT instr);
      srcT s;
      s.rs    = instr[8:6];
      s.rt    = instr[5:3];
      s.useRs = 1'b0;
      s.useRt = 1'b0;
      case (instr[15:12])
         OpAdd, OpSub, OpAnd, OpXor: begin
            s.useRs = 1'b1;
            s.useRt = 1'b1;
         end
         OpAddi, OpLd: s.useRs = 1'b1;
         OpSt: begin
            s.useRs = 1'b1;
            s.useRt = 1'b1;
            s.rt    = instr[11:9];
         end
         OpBeqz: begin
            s.useRs = 1'b1;
            s.rs    = instr[11:9];
         end
         default: ;
      endcase
      return s;
   endfunction

endpackage

//--- tb/procTb.sv
/*
   Testbench for the five-stage core: two programs, reset between them.
   Instruction memory is 64 words, indexed by the low six address bits.
   Ack delays of 0 to 5 cycles come from $random with a fixed seed.
   The model assumes zeroed registers after reset and never loads
   a data word that the program did not store first.
*/
module procTb import procPkg::*;;

   localparam int   Skew          = 2;
   localparam int   Prog1Len      = 28;
   localparam int   Prog2Len      = 11;
   localparam int   TimeoutCycles = 200 * (Prog1Len + Prog2Len) * 6;
   localparam wordT StartPc       = 16'h0000;
   localparam int   DataWords     = 256;

   logic   clk;
   logic   rst;
   logic   imemReq;
   wordT   imemAddr;
   logic   imemAck;
   wordT   imemData;
   logic   retireValid;
   regIdxT retireReg;
   wordT   retireData;
   logic   halt;
   logic   err;

   wordT        imem [64];
   logic [18:0] expQ [$];
   logic        expErr;
   logic        checking;
   logic        prevReq;
   logic        prevAck;
   logic        prevHalt;
   wordT        prevAddr;
   int          errors;
   int          retired;
   integer      seed = 32'h7606_e726;

   proc #(.ResetPc(StartPc), .DmemWords(DataWords)) dut0 (
      .clk(clk), .rst(rst), .imemReq(imemReq), .imemAddr(imemAddr),
      .imemAck(imemAck), .imemData(imemData), .retireValid(retireValid),
      .retireReg(retireReg), .retireData(retireData), .halt(halt), .err(err));

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = 1'b1;
         #20 clk = 1'b0;
      end
   end

   initial begin
      repeat (TimeoutCycles) @(posedge clk);
      $display("Timeout: the core did not halt within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
   end

   task automatic valueError(input string sig, input wordT expected, input wordT actual);
      $display("FAILED at time %0t: %s expected %h, got %h", $time, sig, expected, actual);
      errors++;
   endtask

   task automatic reportProblem(input string what);
      $display("Error at time %0t: %s", $time, what);
      errors++;
   endtask

   function automatic wordT encR(opT op, regIdxT rd, regIdxT rs, regIdxT rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic wordT encI6(opT op, regIdxT rd, regIdxT rs, logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic wordT encI9(opT op, regIdxT rd, logic [8:0] imm);
      return {op, rd, imm};
   endfunction

   // HALT words carrying their own index, so a runaway fetch stops
   task automatic fillImem();
      for (int i = 0; i < 64; i++) begin
         imem[i] = {OpHalt, 6'(i), 6'(i)};
      end
   endtask

   task automatic loadArithProgram();
      fillImem();
      imem[0]  = encI9(OpLbi, 3'd1, 9'd5);
      imem[1]  = encI9(OpLbi, 3'd2, -9'sd3);
      imem[2]  = encR(OpAdd, 3'd3, 3'd1, 3'd2);
      imem[3]  = encR(OpSub, 3'd4, 3'd3, 3'd1);
      imem[4]  = encR(OpAnd, 3'd5, 3'd4, 3'd3);
      imem[5]  = encR(OpXor, 3'd6, 3'd5, 3'd4);
      imem[6]  = encI6(OpAddi, 3'd7, 3'd6, 6'd7);
      imem[7]  = encI6(OpAddi, 3'd0, 3'd7, -6'sd1);
      imem[8]  = encR(OpAdd, 3'd1, 3'd0, 3'd0);
      imem[9]  = encI9(OpLbi, 3'd2, 9'h020);
      imem[10] = encI6(OpSt, 3'd1, 3'd2, 6'd0);
      imem[11] = encI6(OpSt, 3'd3, 3'd2, 6'd1);
      imem[12] = encI6(OpLd, 3'd4, 3'd2, 6'd0);
      imem[13] = encR(OpAdd, 3'd5, 3'd4, 3'd4);
      imem[14] = encI6(OpLd, 3'd6, 3'd2, 6'd1);
      imem[15] = encR(OpXor, 3'd7, 3'd5, 3'd6);
      imem[16] = encI9(OpLbi, 3'd3, 9'd0);
      // Taken branch over the next two
      imem[17] = encI9(OpBeqz, 3'd3, 9'd2);
      imem[18] = encI9(OpLbi, 3'd4, 9'd99);
      imem[19] = encI6(OpAddi, 3'd5, 3'd5, 6'd1);
      imem[20] = encI9(OpBeqz, 3'd1, 9'd1);
      imem[21] = encI6(OpAddi, 3'd6, 3'd6, 6'd3);
      imem[22] = encI6(OpSt, 3'd6, 3'd2, 6'd2);
      imem[23] = encI6(OpLd, 3'd0, 3'd2, 6'd2);
      imem[24] = encR(OpAdd, 3'd1, 3'd0, 3'd2);
      imem[25] = {OpHalt, 12'h000};
      imem[26] = encI9(OpLbi, 3'd2, 9'd77);
      imem[27] = encI9(OpLbi, 3'd3, 9'd1);
   endtask

   task automatic loadIllegalProgram();
      fillImem();
      imem[0]  = encI9(OpLbi, 3'd1, 9'd10);
      imem[1]  = encI6(OpAddi, 3'd2, 3'd1, -6'sd4);
      imem[2]  = encI6(OpSt, 3'd2, 3'd1, 6'd0);
      imem[3]  = encI6(OpLd, 3'd3, 3'd1, 6'd0);
      imem[4]  = encR(OpSub, 3'd4, 3'd3, 3'd2);
      imem[5]  = encI9(OpBeqz, 3'd4, 9'd1);
      imem[6]  = encI9(OpLbi, 3'd5, 9'd55);
      imem[7]  = encR(OpXor, 3'd5, 3'd4, 3'd1);
      imem[8]  = 16'hC000;
      imem[9]  = encR(OpAdd, 3'd6, 3'd1, 3'd1);
      imem[10] = {OpHalt, 12'h000};
   endtask

   // ISA-level interpreter, one instruction per step
   task automatic buildExpected();
      wordT        r [8];
      wordT        dm [DataWords];
      wordT        pc;
      wordT        ins;
      wordT        imm6;
      wordT        imm9;
      wordT        res;
      wordT        addr;
      regIdxT      rd;
      regIdxT      rs;
      regIdxT      rt;
      logic        writes;
      logic        done;
      int          steps;
      expQ.delete();
      expErr = 1'b0;
      for (int i = 0; i < 8; i++) begin
         r[i] = '0;
      end
      pc    = StartPc;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         ins    = imem[pc[5:0]];
         rd     = ins[11:9];
         rs     = ins[8:6];
         rt     = ins[5:3];
         imm6   = {{10{ins[5]}}, ins[5:0]};
         imm9   = {{7{ins[8]}}, ins[8:0]};
         addr   = (r[rs] + imm6) % DataWords;
         writes = 1'b1;
         res    = '0;
         case (ins[15:12])
            4'h1: res = r[rs] + r[rt];
            4'h2: res = r[rs] - r[rt];
            4'h3: res = r[rs] & r[rt];
            4'h4: res = r[rs] ^ r[rt];
            4'h5: res = r[rs] + imm6;
            4'h6: res = imm9;
            4'h7: res = dm[addr];
            4'h8: begin
               dm[addr] = r[rd];
               writes   = 1'b0;
            end
            4'h9: begin
               writes = 1'b0;
               if (r[rd] == '0) begin
                  pc = pc + imm9;
               end
            end
            4'h0: writes = 1'b0;
            4'hA: begin
               writes = 1'b0;
               done   = 1'b1;
            end
            default: begin
               writes = 1'b0;
               done   = 1'b1;
               expErr = 1'b1;
            end
         endcase
         if (writes) begin
            r[rd] = res;
            expQ.push_back({rd, res});
         end
         pc = pc + 16'd1;
         steps++;
      end
   endtask

   task automatic applyReset();
      @(posedge clk);
      #Skew;
      rst      = 1'b1;
      checking = 1'b0;
      repeat (15) @(posedge clk);
      @(negedge clk);
      assert (imemReq === 1'b0 && retireValid === 1'b0 && halt === 1'b0 && err === 1'b0)
         else reportProblem("outputs not low during reset");
      @(posedge clk);
      #Skew;
      rst      = 1'b0;
      checking = 1'b1;
   endtask

   task automatic runProgram(input string name, input int which);
      int startErrors;
      int startRetired;
      startErrors  = errors;
      startRetired = retired;
      // The old run stays halted while the new model is built
      checking     = 1'b0;
      if (which == 1) begin
         loadArithProgram();
      end else begin
         loadIllegalProgram();
      end
      buildExpected();
      applyReset();
      do @(negedge clk); while (halt !== 1'b1);
      // Halt must hold with no retire and no fetch afterward
      repeat (40) @(negedge clk);
      assert (expQ.size() == 0)
         else reportProblem("model writes were never retired");
      $display("%s: %0d retires checked, %0d errors", name, retired - startRetired,
               errors - startErrors);
   endtask

   // Four-phase responder with random delay before each ack edge
   initial begin
      int d;
      forever begin
         @(negedge clk);
         if (imemReq === 1'b1 && imemAck === 1'b0) begin
            d = $unsigned($random(seed)) % 6;
            repeat (d) @(posedge clk);
            @(posedge clk);
            #Skew;
            imemData = imem[imemAddr[5:0]];
            imemAck  = 1'b1;
            do @(negedge clk); while (imemReq === 1'b1);
            d = $unsigned($random(seed)) % 6;
            repeat (d) @(posedge clk);
            @(posedge clk);
            #Skew;
            imemAck = 1'b0;
         end
      end
   end

   always @(negedge clk) begin
      logic [18:0] head;
      if (checking) begin
         assert (!$isunknown(retireValid)) else reportProblem("retireValid is unknown");
         if (retireValid === 1'b1) begin
            if (expQ.size() == 0) begin
               reportProblem("retire seen with no write left in the model");
            end else begin
               head = expQ.pop_front();
               assert (retireReg === head[18:16])
                  else valueError("retireReg", {13'b0, head[18:16]}, {13'b0, retireReg});
               assert (retireData === head[15:0])
                  else valueError("retireData", head[15:0], retireData);
               retired++;
            end
         end
         if (halt === 1'b1 && !prevHalt) begin
            assert (expQ.size() == 0)
               else reportProblem("halt rose before all older writes retired");
         end
         assert (!prevHalt || halt === 1'b1) else reportProblem("halt fell while halted");
         assert (err === (halt && expErr))
            else valueError("err", {15'b0, halt && expErr}, {15'b0, err});
         if ((imemReq === 1'b1 || imemAck === 1'b1) && (prevReq || prevAck)) begin
            assert (imemAddr === prevAddr) else valueError("imemAddr", prevAddr, imemAddr);
         end
         if (imemReq === 1'b1 && !prevReq) begin
            assert (!prevAck && imemAck === 1'b0)
               else reportProblem("imemReq rose before imemAck fell");
            assert (!prevHalt) else reportProblem("imemReq rose after halt");
         end
      end
      prevReq  = (imemReq === 1'b1);
      prevAck  = (imemAck === 1'b1);
      prevHalt = (halt === 1'b1);
      prevAddr = imemAddr;
   end

   initial begin
      rst      = 1'b1;
      imemAck  = 1'b0;
      imemData = '0;
      checking = 1'b0;
      expErr   = 1'b0;
      prevReq  = 1'b0;
      prevAck  = 1'b0;
      prevHalt = 1'b0;
      prevAddr = '0;
      errors   = 0;
      retired  = 0;
      runProgram("ALU, memory and branch program", 1);
      runProgram("Illegal opcode program", 2);
      $display("Done: 2 programs, %0d retires checked, %0d errors", retired, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
